//--- build.f
+incdir+.
lsu_pkg.sv
lsu_req_if.sv
lsu_agu.sv
lsu_load_ext.sv
lsu_ctrl.sv
lsu_top.sv
lsu_checker.sv
tb_lsu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := All tests passed!

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) lsu_defines.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)

check: run
	@if grep -qF "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_lsu.sv
// testbench for the load/store unit with memory model, random instructions and timeout.

`timescale 1ns/1ps

`include "lsu_defines.svh"

module tb_lsu;

    localparam int NUM_INSTS  = 60;
    localparam int MAX_CYCLES = NUM_INSTS * 8 + 100;

    logic              clk, rst_n, mem_read_ready, mem_write_ready;
    logic              mem_read_en, mem_write_en, busy, wb_rd_wait, rd_en;
    lsu_pkg::xlen_t    pc, rs1_data, rs2_data, mem_rdata, mem_addr, mem_wdata, rd_data;
    lsu_pkg::flags_t   inst_flags;
    lsu_pkg::imm12_t   imm;
    lsu_pkg::size_t    mem_size;
    lsu_pkg::reg_idx_t rd, rd_out;

    lsu_pkg::xlen_t mem [256];
    int             seed;
    int             cycles = 0;
    int             op_bit [8] = '{`LSU_FLAG_LB, `LSU_FLAG_LBU, `LSU_FLAG_LH, `LSU_FLAG_LHU,
                                   `LSU_FLAG_LW, `LSU_FLAG_SB, `LSU_FLAG_SH, `LSU_FLAG_SW};

    lsu_top dut (.*);

    bind lsu_top lsu_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // stop at the first checker failure or when the run takes too long.
    always @(negedge clk) begin
        cycles++;
        if (dut.chk.failed) begin
            $display("Test failures found");
            $fatal(1, "checker assertion failed");
        end else if (cycles > MAX_CYCLES) begin
            $display("Test failures found");
            $fatal(1, "timeout, run did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    // one random op, then serve the memory until busy drops.
    task automatic run_instruction(input logic same_pc);
        int         op;
        int         wait_left;
        logic [7:0] idx;
        op = $unsigned($random(seed)) % 8;
        inst_flags = '0;
        inst_flags[op_bit[op]] = 1'b1;
        rd        = lsu_pkg::reg_idx_t'($random(seed));
        rs1_data  = $random(seed);
        rs2_data  = $random(seed);
        imm       = lsu_pkg::imm12_t'($random(seed));
        pc        = same_pc ? pc : pc + 32'd4;
        wait_left = $unsigned($random(seed)) % 4;
        @(negedge clk);
        while (busy) begin
            idx = mem_addr[9:2];
            mem_read_ready  = 1'b0;
            mem_write_ready = 1'b0;
            if (mem_read_en || mem_write_en) begin
                if (wait_left > 0) begin
                    wait_left--;
                end else if (mem_read_en) begin
                    case (mem_size)
                        2'd1:    mem_rdata = {24'h0, mem[idx][7:0]};
                        2'd2:    mem_rdata = {16'h0, mem[idx][15:0]};
                        default: mem_rdata = mem[idx];
                    endcase
                    mem_read_ready = 1'b1;
                end else begin
                    mem[idx]        = mem_wdata;
                    mem_write_ready = 1'b1;
                end
            end
            @(negedge clk);
        end
    endtask

    initial begin
        seed            = 32'h0419_8712;
        rst_n           = 1'b1;
        pc              = 32'h0000_0100;
        inst_flags      = '0;
        rd              = '0;
        rs1_data        = '0;
        rs2_data        = '0;
        imm             = '0;
        mem_rdata       = '0;
        mem_read_ready  = 1'b0;
        mem_write_ready = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i + 1) * 32'h9e37_79b9;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b0;
        @(negedge clk);
        // every seventh op keeps the pc of the one before.
        for (int n = 0; n < NUM_INSTS; n++) begin
            run_instruction(n % 7 == 3);
        end
        repeat (3) @(negedge clk);
        if (dut.chk.failed) begin
            $display("Test failures found");
            $fatal(1, "checker assertion failed");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

//--- lsu_checker.sv
// bound assertions on addresses, store data, load extension and strobe timing.

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_checker (
    input logic              clk, rst_n, busy, wb_rd_wait, rd_en,
    input logic              mem_read_en, mem_write_en, mem_read_ready, mem_write_ready,
    input lsu_pkg::xlen_t    pc, rs1_data, rs2_data, mem_rdata, mem_addr, mem_wdata, rd_data,
    input lsu_pkg::flags_t   inst_flags,
    input lsu_pkg::imm12_t   imm,
    input lsu_pkg::size_t    mem_size,
    input lsu_pkg::reg_idx_t rd, rd_out
);

    logic              is_st;
    logic              is_byte;
    logic              is_half;
    logic              sh_signed;
    logic              failed = 1'b0;
    lsu_pkg::size_t    exp_size;
    lsu_pkg::size_t    sh_size;
    lsu_pkg::imm12_t   offset;
    lsu_pkg::reg_idx_t sh_rd;
    lsu_pkg::xlen_t    exp_addr;
    lsu_pkg::xlen_t    exp_wdata;
    lsu_pkg::xlen_t    exp_rd_data;
    lsu_pkg::xlen_t    prev_pc;

    function automatic lsu_pkg::xlen_t size_mask(input lsu_pkg::size_t s);
        return (s == 2'd1) ? 32'h0000_00ff : ((s == 2'd2) ? 32'h0000_ffff : 32'hffff_ffff);
    endfunction

    // field kept, upper bits from the field's top bit when signed.
    function automatic lsu_pkg::xlen_t extend(input lsu_pkg::xlen_t raw,
                                              input lsu_pkg::size_t s, input logic sgn);
        lsu_pkg::xlen_t m;
        logic           top;
        m   = size_mask(s);
        top = (s == 2'd1) ? raw[7] : raw[15];
        return (raw & m) | ((sgn && s != 2'd0 && top) ? ~m : '0);
    endfunction

    // --------------------
    // expected request
    // --------------------

    assign is_st     = inst_flags[`LSU_FLAG_SB] | inst_flags[`LSU_FLAG_SH] |
                       inst_flags[`LSU_FLAG_SW];
    assign is_byte   = inst_flags[`LSU_FLAG_LB] | inst_flags[`LSU_FLAG_LBU] |
                       inst_flags[`LSU_FLAG_SB];
    assign is_half   = inst_flags[`LSU_FLAG_LH] | inst_flags[`LSU_FLAG_LHU] |
                       inst_flags[`LSU_FLAG_SH];
    assign exp_size  = is_byte ? 2'd1 : (is_half ? 2'd2 : 2'd0);
    assign offset    = is_st ? {imm[11:5], rd} : imm;
    assign exp_addr  = rs1_data + {{20{offset[11]}}, offset};
    assign exp_wdata = rs2_data & size_mask(exp_size);

    // shadow of the instruction seen while idle and frozen once busy.
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            prev_pc     <= '0;
            sh_rd       <= '0;
            sh_size     <= '0;
            sh_signed   <= 1'b0;
            exp_rd_data <= '0;
        end else begin
            if (!busy) begin
                prev_pc   <= pc;
                sh_rd     <= rd;
                sh_size   <= exp_size;
                sh_signed <= inst_flags[`LSU_FLAG_LB] | inst_flags[`LSU_FLAG_LH];
            end
            if (mem_read_en && mem_read_ready) begin
                exp_rd_data <= extend(mem_rdata, sh_size, sh_signed);
            end
        end
    end

    // --------------------
    // assertions
    // --------------------

    // a memory op under a new pc while idle starts its access on the next edge.
    new_issue: assert property (@(posedge clk) disable iff (rst_n)
        !busy && pc != prev_pc && (|inst_flags[`LSU_FLAG_SW:`LSU_FLAG_LB]) |=>
            busy && mem_write_en == $past(is_st) && mem_read_en == !$past(is_st))
    else begin
        $error("MISMATCH at %0t: memory instruction with a new pc did not issue", $time);
        failed = 1'b1;
    end

    issue_req: assert property (@(posedge clk) disable iff (rst_n)
        $rose(mem_read_en || mem_write_en) |-> !$past(busy) && mem_addr == $past(exp_addr)
            && mem_size == $past(exp_size) && (!mem_write_en || mem_wdata == $past(exp_wdata)))
    else begin
        $error("MISMATCH at %0t: address, size or store data at issue", $time);
        failed = 1'b1;
    end

    // back-pressure holds the whole request.
    hold_req: assert property (@(posedge clk) disable iff (rst_n)
        (mem_read_en && !mem_read_ready) || (mem_write_en && !mem_write_ready) |=>
            (mem_read_en || mem_write_en) && $stable(mem_addr) && $stable(mem_wdata)
            && $stable(mem_size))
    else begin
        $error("MISMATCH at %0t: request changed while ready was low", $time);
        failed = 1'b1;
    end

    release_req: assert property (@(posedge clk) disable iff (rst_n)
        (mem_read_en && mem_read_ready) || (mem_write_en && mem_write_ready) |=>
            !mem_read_en && !mem_write_en && busy ##1 !busy && !rd_en && !wb_rd_wait)
    else begin
        $error("MISMATCH at %0t: strobe or busy timing after ready", $time);
        failed = 1'b1;
    end

    load_result: assert property (@(posedge clk) disable iff (rst_n)
        mem_read_en && mem_read_ready |=>
            rd_en && wb_rd_wait && rd_data == exp_rd_data && rd_out == sh_rd)
    else begin
        $error("MISMATCH at %0t: writeback data %h, expected %h", $time, rd_data, exp_rd_data);
        failed = 1'b1;
    end

    strobe_excl: assert property (@(posedge clk) disable iff (rst_n)
        !(mem_read_en && mem_write_en) && (!mem_read_en || wb_rd_wait))
    else begin
        $error("MISMATCH at %0t: read and write strobes overlap or wb_rd_wait low", $time);
        failed = 1'b1;
    end

    same_pc: assert property (@(posedge clk) disable iff (rst_n)
        !busy && pc == prev_pc |=> !mem_read_en && !mem_write_en)
    else begin
        $error("MISMATCH at %0t: access started for an unchanged pc", $time);
        failed = 1'b1;
    end

    reset_quiet: assert property (@(posedge clk)
        rst_n || $past(rst_n) |-> !(mem_read_en || mem_write_en || rd_en || busy || wb_rd_wait))
    else begin
        $error("MISMATCH at %0t: control output high in reset", $time);
        failed = 1'b1;
    end

endmodule

//--- lsu_top.sv
// top level of the load/store stage with generator, extender and controller.

`timescale 1ns/1ps

module lsu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  lsu_pkg::xlen_t    pc,
    input  lsu_pkg::flags_t   inst_flags,
    input  lsu_pkg::reg_idx_t rd,
    input  lsu_pkg::xlen_t    rs1_data,
    input  lsu_pkg::xlen_t    rs2_data,
    input  lsu_pkg::imm12_t   imm,
    input  lsu_pkg::xlen_t    mem_rdata,
    input  logic              mem_read_ready,
    input  logic              mem_write_ready,
    output lsu_pkg::xlen_t    mem_addr,
    output lsu_pkg::xlen_t    mem_wdata,
    output lsu_pkg::size_t    mem_size,
    output logic              mem_read_en,
    output logic              mem_write_en,
    output logic              busy,
    output logic              wb_rd_wait,
    output lsu_pkg::reg_idx_t rd_out,
    output logic              rd_en,
    output lsu_pkg::xlen_t    rd_data
);

    lsu_req_if req_bus ();

    lsu_pkg::size_t load_size;
    logic           load_signed;
    lsu_pkg::xlen_t load_ext;

    lsu_agu u_agu (
        .inst_flags (inst_flags),
        .rd         (rd),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .req        (req_bus.agu)
    );

    // extension sees the raw bus and the latched request.
    lsu_load_ext u_load_ext (
        .raw         (mem_rdata),
        .size        (load_size),
        .load_signed (load_signed),
        .ext         (load_ext)
    );

    lsu_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .pc              (pc),
        .rd              (rd),
        .req             (req_bus.ctrl),
        .mem_read_ready  (mem_read_ready),
        .mem_write_ready (mem_write_ready),
        .load_ext        (load_ext),
        .load_size       (load_size),
        .load_signed     (load_signed),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_size        (mem_size),
        .mem_read_en     (mem_read_en),
        .mem_write_en    (mem_write_en),
        .busy            (busy),
        .wb_rd_wait      (wb_rd_wait),
        .rd_out          (rd_out),
        .rd_en           (rd_en),
        .rd_data         (rd_data)
    );

endmodule

//--- lsu_ctrl.sv
// access controller FSM with memory strobes, writeback strobe and busy.

`timescale 1ns/1ps

module lsu_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  lsu_pkg::xlen_t    pc,
    input  lsu_pkg::reg_idx_t rd,
    lsu_req_if.ctrl           req,
    input  logic              mem_read_ready,
    input  logic              mem_write_ready,
    input  lsu_pkg::xlen_t    load_ext,
    output lsu_pkg::size_t    load_size,
    output logic              load_signed,
    output lsu_pkg::xlen_t    mem_addr,
    output lsu_pkg::xlen_t    mem_wdata,
    output lsu_pkg::size_t    mem_size,
    output logic              mem_read_en,
    output logic              mem_write_en,
    output logic              busy,
    output logic              wb_rd_wait,
    output lsu_pkg::reg_idx_t rd_out,
    output logic              rd_en,
    output lsu_pkg::xlen_t    rd_data
);

    lsu_pkg::lsu_state_e state;
    lsu_pkg::lsu_state_e state_next;
    lsu_pkg::xlen_t      last_pc;
    logic                new_inst;
    logic                issue;

    // a changed pc marks a new instruction.
    assign new_inst = (pc != last_pc);
    assign issue    = (state == lsu_pkg::IDLE) && new_inst &&
                      (req.is_load || req.is_store);

    // latched size drives the extender.
    assign load_size = mem_size;

    // --------------------
    // next state
    // --------------------

    always_comb begin
        state_next = state;
        case (state)
            lsu_pkg::IDLE: begin
                if (issue) begin
                    state_next = req.is_load ? lsu_pkg::READ : lsu_pkg::WRITE;
                end
            end
            lsu_pkg::READ: begin
                if (mem_read_ready) begin
                    state_next = lsu_pkg::DONE;
                end
            end
            lsu_pkg::WRITE: begin
                if (mem_write_ready) begin
                    state_next = lsu_pkg::DONE;
                end
            end
            lsu_pkg::DONE: begin
                state_next = lsu_pkg::IDLE;
            end
            default: begin
                state_next = lsu_pkg::IDLE;
            end
        endcase
    end

    // --------------------
    // registers
    // --------------------

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            state        <= lsu_pkg::IDLE;
            last_pc      <= '0;
            mem_addr     <= '0;
            mem_wdata    <= '0;
            mem_size     <= lsu_pkg::SIZE_WORD;
            mem_read_en  <= 1'b0;
            mem_write_en <= 1'b0;
            busy         <= 1'b0;
            wb_rd_wait   <= 1'b0;
            rd_out       <= '0;
            rd_en        <= 1'b0;
            rd_data      <= '0;
            load_signed  <= 1'b0;
        end else begin
            state <= state_next;
            case (state)
                lsu_pkg::IDLE: begin
                    last_pc <= pc;
                    if (issue) begin
                        mem_addr     <= req.addr;
                        mem_wdata    <= req.wdata;
                        mem_size     <= req.size;
                        mem_read_en  <= req.is_load;
                        mem_write_en <= ~req.is_load;
                        busy         <= 1'b1;
                        // rd_out stays put across stores.
                        if (req.is_load) begin
                            wb_rd_wait  <= 1'b1;
                            rd_out      <= rd;
                            load_signed <= req.load_signed;
                        end
                    end
                end
                lsu_pkg::READ: begin
                    if (mem_read_ready) begin
                        mem_read_en <= 1'b0;
                        rd_data     <= load_ext;
                        rd_en       <= 1'b1;
                    end
                end
                lsu_pkg::WRITE: begin
                    if (mem_write_ready) begin
                        mem_write_en <= 1'b0;
                    end
                end
                default: begin
                    // DONE, one cycle of rd_en then release.
                    rd_en      <= 1'b0;
                    busy       <= 1'b0;
                    wb_rd_wait <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- lsu_load_ext.sv
// sign or zero extension of returned load data.

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_load_ext (
    input  lsu_pkg::xlen_t raw,
    input  lsu_pkg::size_t size,
    input  logic           load_signed,
    output lsu_pkg::xlen_t ext
);

    logic byte_fill;
    logic half_fill;

    // memory already puts the field in the low bits.
    // only the fill bit depends on signedness.
    assign byte_fill = load_signed & raw[7];
    assign half_fill = load_signed & raw[15];

    always_comb begin
        case (size)
            lsu_pkg::SIZE_BYTE: begin
                ext = {{(`LSU_XLEN-8){byte_fill}}, raw[7:0]};
            end
            lsu_pkg::SIZE_HALF: begin
                ext = {{(`LSU_XLEN-16){half_fill}}, raw[15:0]};
            end
            default: begin
                // word loads pass through.
                ext = raw;
            end
        endcase
    end

endmodule

//--- lsu_agu.sv
// address and store data generator for the memory instructions.

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_agu (
    input  lsu_pkg::flags_t   inst_flags,
    input  lsu_pkg::reg_idx_t rd,
    input  lsu_pkg::xlen_t    rs1_data,
    input  lsu_pkg::xlen_t    rs2_data,
    input  lsu_pkg::imm12_t   imm,
    lsu_req_if.agu            req
);

    logic is_lb;
    logic is_lbu;
    logic is_lh;
    logic is_lhu;
    logic is_lw;
    logic is_sb;
    logic is_sh;
    logic is_sw;

    lsu_pkg::size_t  acc_size;
    lsu_pkg::imm12_t offset;
    lsu_pkg::xlen_t  offset_ext;

    // --------------------
    // flag decode
    // --------------------

    assign is_lb  = inst_flags[`LSU_FLAG_LB];
    assign is_lbu = inst_flags[`LSU_FLAG_LBU];
    assign is_lh  = inst_flags[`LSU_FLAG_LH];
    assign is_lhu = inst_flags[`LSU_FLAG_LHU];
    assign is_lw  = inst_flags[`LSU_FLAG_LW];
    assign is_sb  = inst_flags[`LSU_FLAG_SB];
    assign is_sh  = inst_flags[`LSU_FLAG_SH];
    assign is_sw  = inst_flags[`LSU_FLAG_SW];

    assign req.is_load     = is_lb | is_lbu | is_lh | is_lhu | is_lw;
    assign req.is_store    = is_sb | is_sh | is_sw;
    assign req.load_signed = is_lb | is_lh;

    // byte and halfword ops, everything else is a word.
    always_comb begin
        if (is_lb || is_lbu || is_sb) begin
            acc_size = lsu_pkg::SIZE_BYTE;
        end else if (is_lh || is_lhu || is_sh) begin
            acc_size = lsu_pkg::SIZE_HALF;
        end else begin
            acc_size = lsu_pkg::SIZE_WORD;
        end
    end

    assign req.size = acc_size;

    // --------------------
    // address
    // --------------------

    // s-type splits the offset around the rd field.
    assign offset     = req.is_store ? {imm[11:5], rd} : imm;
    assign offset_ext = {{(`LSU_XLEN-12){offset[11]}}, offset};
    assign req.addr   = rs1_data + offset_ext;

    // store data, zero above the access size.
    always_comb begin
        case (acc_size)
            lsu_pkg::SIZE_BYTE: req.wdata = {{(`LSU_XLEN-8){1'b0}}, rs2_data[7:0]};
            lsu_pkg::SIZE_HALF: req.wdata = {{(`LSU_XLEN-16){1'b0}}, rs2_data[15:0]};
            default:            req.wdata = rs2_data;
        endcase
    end

endmodule

//--- lsu_req_if.sv
// interface carrying one computed memory access from the generator to the controller.

`timescale 1ns/1ps

interface lsu_req_if;

    // access kind.
    logic is_load;
    logic is_store;

    // effective address, rs1 plus sign-extended offset.
    lsu_pkg::xlen_t addr;

    // size code for the memory port.
    lsu_pkg::size_t size;

    // store data, already cut down to the access size.
    lsu_pkg::xlen_t wdata;

    // high for lb and lh.
    logic load_signed;

    // generator side drives everything.
    modport agu (
        output is_load,
        output is_store,
        output addr,
        output size,
        output wdata,
        output load_signed
    );

    modport ctrl (
        input is_load,
        input is_store,
        input addr,
        input size,
        input wdata,
        input load_signed
    );

endinterface

//--- lsu_pkg.sv
// shared types, size codes and controller states of the load/store unit.

`include "lsu_defines.svh"

package lsu_pkg;

    // --------------------
    // vector types
    // --------------------

    // data or address word.
    typedef logic [`LSU_XLEN-1:0] xlen_t;

    // destination register index.
    typedef logic [4:0] reg_idx_t;

    // raw immediate field from the instruction.
    typedef logic [11:0] imm12_t;

    // decoded instruction flags.
    typedef logic [`LSU_FLAGS_W-1:0] flags_t;

    // access size on the memory port.
    typedef logic [1:0] size_t;

    // size codes as seen by the memory.
    localparam size_t SIZE_WORD = 2'd0;
    localparam size_t SIZE_BYTE = 2'd1;
    localparam size_t SIZE_HALF = 2'd2;

    // --------------------
    // controller FSM
    // --------------------

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        DONE
    } lsu_state_e;

endpackage

//--- lsu_defines.svh
// width and flag position macros for the load/store unit.

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// --------------------
// datapath widths
// --------------------

// data and address word.
`define LSU_XLEN 32

// decoded instruction flag vector from the decode stage.
`define LSU_FLAGS_W 48

// --------------------
// memory flag bits
// --------------------

// one-hot position of each memory instruction.
// loads come first.
`define LSU_FLAG_LB  29
`define LSU_FLAG_LBU 30
`define LSU_FLAG_LH  31
`define LSU_FLAG_LHU 32
`define LSU_FLAG_LW  33

// stores follow the loads.
`define LSU_FLAG_SB  34
`define LSU_FLAG_SH  35
`define LSU_FLAG_SW  36

// the remaining flag bits belong to other
// execution units and are ignored here.

`endif
